/* rtl/ata_pkg.sv */
// ATA task-file constants shared by the PIO sector reader.
// Register addresses, command codes, status bits and host register map.
`default_nettype none

package ata_pkg;

   // chip selects {cs1, cs0} followed by the register number
   localparam int ata_addr_w = 5;

   // command block is selected with cs0 low
   localparam logic [ata_addr_w-1:0] tf_data       = {2'b10, 3'd0};
   localparam logic [ata_addr_w-1:0] tf_seccnt     = {2'b10, 3'd2};
   localparam logic [ata_addr_w-1:0] tf_lba0       = {2'b10, 3'd3};
   localparam logic [ata_addr_w-1:0] tf_lba1       = {2'b10, 3'd4};
   localparam logic [ata_addr_w-1:0] tf_lba2       = {2'b10, 3'd5};
   localparam logic [ata_addr_w-1:0] tf_device     = {2'b10, 3'd6};
   localparam logic [ata_addr_w-1:0] tf_cmd_status = {2'b10, 3'd7};

   localparam logic [7:0] cmd_read_sectors = 8'h20;

   // LBA addressing, master drive
   localparam logic [3:0] device_lba_mode = 4'hE;

   // status byte bits
   localparam int st_bsy = 7;
   localparam int st_drq = 3;
   localparam int st_err = 0;

   localparam int sector_words = 256;

   // host register map
   localparam logic [2:0] reg_ctrl   = 3'd0;
   localparam logic [2:0] reg_lba_lo = 3'd1;
   localparam logic [2:0] reg_lba_hi = 3'd2;
   localparam logic [2:0] reg_status = 3'd3;

endpackage

`default_nettype wire

/* rtl/ata_pio_cycle.sv */
// IDE PIO register cycle engine.
// Runs one read or write on the IDE bus with a stretched strobe,
// a fixed recovery time and a done pulse at the end.
`timescale 1ns/1ps
`default_nettype none

module ata_pio_cycle #(
   parameter logic [5:0] strobe_cycles = 6'd13
) (
   input  wire logic                           clk,
   input  wire logic                           reset,
   input  wire logic                           ata_rd,
   input  wire logic                           ata_wr,
   input  wire logic [ata_pkg::ata_addr_w-1:0] ata_addr,
   input  wire logic [15:0]                    ata_in,
   output logic      [15:0]                    ata_out,
   output logic                                ata_done,
   input  wire logic [15:0]                    ide_data_in,
   output logic      [15:0]                    ide_data_out,
   output logic                                ide_dior,
   output logic                                ide_diow,
   output logic      [1:0]                     ide_cs,
   output logic      [2:0]                     ide_da
);

   localparam logic [3:0] s_idle    = 4'd0;
   localparam logic [3:0] s_setup   = 4'd1;
   localparam logic [3:0] s_strobe  = 4'd2;
   localparam logic [3:0] s_release = 4'd3;
   localparam logic [3:0] s_rec0    = 4'd4;
   localparam logic [3:0] s_rec1    = 4'd5;
   localparam logic [3:0] s_rec2    = 4'd6;
   localparam logic [3:0] s_rec3    = 4'd7;
   localparam logic [3:0] s_rec4    = 4'd8;
   localparam logic [3:0] s_done    = 4'd9;

   logic [3:0]  state;
   logic [3:0]  state_next;
   logic [5:0]  strobe_cnt;
   logic        op_rd;
   logic        op_wr;
   logic        req_accept;
   logic [15:0] rd_word;

   assign req_accept = (state == s_idle) && (ata_rd || ata_wr);

   always_comb
   begin
      state_next = state;
      case (state)
         s_idle:    if (ata_rd || ata_wr) state_next = s_setup;
         s_setup:   state_next = s_strobe;
         s_strobe:  if (strobe_cnt == strobe_cycles) state_next = s_release;
         s_release: state_next = s_rec0;
         s_rec0:    state_next = s_rec1;
         s_rec1:    state_next = s_rec2;
         s_rec2:    state_next = s_rec3;
         s_rec3:    state_next = s_rec4;
         s_rec4:    state_next = s_done;
         default:   state_next = s_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= s_idle;
      else
         state <= state_next;
   end

   // strobe length counter
   always_ff @(posedge clk)
   begin
      if (reset)
         strobe_cnt <= '0;
      else if (state == s_setup)
         strobe_cnt <= '0;
      else if (state == s_strobe)
         strobe_cnt <= strobe_cnt + 6'd1;
   end

   // the request is only a one-cycle pulse, so remember its direction
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         op_rd <= 1'b0;
         op_wr <= 1'b0;
      end
      else if (req_accept)
      begin
         op_rd <= ata_rd;
         op_wr <= ata_wr;
      end
   end

   // all bus pins come straight from flops
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ide_dior <= 1'b1;
         ide_diow <= 1'b1;
         ide_cs   <= 2'b11;
         ide_da   <= 3'b111;
      end
      else if (req_accept)
      begin
         ide_cs <= ata_addr[ata_pkg::ata_addr_w-1 -: 2];
         ide_da <= ata_addr[2:0];
      end
      else if (state == s_setup)
      begin
         ide_dior <= ~op_rd;
         ide_diow <= ~op_wr;
      end
      else if (state == s_release)
      begin
         ide_dior <= 1'b1;
         ide_diow <= 1'b1;
         ide_cs   <= 2'b11;
         ide_da   <= 3'b111;
      end
   end

   // write data held for the whole cycle
   always_ff @(posedge clk)
   begin
      if (req_accept)
         ide_data_out <= ata_in;
   end

   // last sample before release wins
   always_ff @(posedge clk)
   begin
      if (state == s_strobe && op_rd)
         rd_word <= ide_data_in;
   end

   assign ata_out  = rd_word;
   assign ata_done = (state == s_done);

endmodule

`default_nettype wire

/* rtl/ata_sector_reader.sv */
// Sector read sequencer.
// Loads the task file, issues READ SECTORS, polls status and
// moves the 256 data words into the sector buffer.
`timescale 1ns/1ps
`default_nettype none

module ata_sector_reader (
   input  wire logic                           clk,
   input  wire logic                           reset,
   input  wire logic                           start,
   input  wire logic [27:0]                    lba,
   output logic                                busy,
   output logic                                finish,
   output logic                                failed,
   output logic                                ata_rd,
   output logic                                ata_wr,
   output logic      [ata_pkg::ata_addr_w-1:0] ata_addr,
   output logic      [15:0]                    ata_in,
   input  wire logic [15:0]                    ata_out,
   input  wire logic                           ata_done,
   output logic                                wr_en,
   output logic      [7:0]                     wr_addr,
   output logic      [15:0]                    wr_data
);

   localparam logic [2:0] st_idle      = 3'd0;
   localparam logic [2:0] st_wr_req    = 3'd1;
   localparam logic [2:0] st_wr_wait   = 3'd2;
   localparam logic [2:0] st_poll_req  = 3'd3;
   localparam logic [2:0] st_poll_wait = 3'd4;
   localparam logic [2:0] st_xfer_req  = 3'd5;
   localparam logic [2:0] st_xfer_wait = 3'd6;

   // six task-file writes, the command goes last
   localparam logic [2:0] tf_last = 3'd5;

   logic [2:0]                     state;
   logic [2:0]                     tf_step;
   logic [7:0]                     word_idx;
   logic [27:0]                    lba_q;
   logic [ata_pkg::ata_addr_w-1:0] tf_addr;
   logic [15:0]                    tf_value;
   logic                           status_err;
   logic                           status_ready;
   logic                           last_word;

   // ERR and DRQ only mean something once BSY has dropped
   assign status_err   = ~ata_out[ata_pkg::st_bsy] & ata_out[ata_pkg::st_err];
   assign status_ready = ~ata_out[ata_pkg::st_bsy] & ata_out[ata_pkg::st_drq];
   assign last_word    = (word_idx == 8'(ata_pkg::sector_words - 1));

   // task-file register and value for each setup step
   always_comb
   begin
      case (tf_step)
         3'd0:
         begin
            tf_addr  = ata_pkg::tf_seccnt;
            tf_value = 16'h0001;
         end
         3'd1:
         begin
            tf_addr  = ata_pkg::tf_lba0;
            tf_value = {8'h00, lba_q[7:0]};
         end
         3'd2:
         begin
            tf_addr  = ata_pkg::tf_lba1;
            tf_value = {8'h00, lba_q[15:8]};
         end
         3'd3:
         begin
            tf_addr  = ata_pkg::tf_lba2;
            tf_value = {8'h00, lba_q[23:16]};
         end
         3'd4:
         begin
            tf_addr  = ata_pkg::tf_device;
            tf_value = {8'h00, ata_pkg::device_lba_mode, lba_q[27:24]};
         end
         default:
         begin
            tf_addr  = ata_pkg::tf_cmd_status;
            tf_value = {8'h00, ata_pkg::cmd_read_sectors};
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= st_idle;
         tf_step  <= '0;
         word_idx <= '0;
      end
      else
      begin
         case (state)
            st_idle:
               if (start)
               begin
                  tf_step <= '0;
                  state   <= st_wr_req;
               end
            st_wr_req:
               state <= st_wr_wait;
            st_wr_wait:
               if (ata_done)
               begin
                  if (tf_step == tf_last)
                     state <= st_poll_req;
                  else
                  begin
                     tf_step <= tf_step + 3'd1;
                     state   <= st_wr_req;
                  end
               end
            st_poll_req:
               state <= st_poll_wait;
            st_poll_wait:
               if (ata_done)
               begin
                  if (status_err)
                     state <= st_idle;
                  else if (status_ready)
                  begin
                     word_idx <= '0;
                     state    <= st_xfer_req;
                  end
                  else
                     state <= st_poll_req;
               end
            st_xfer_req:
               state <= st_xfer_wait;
            st_xfer_wait:
               if (ata_done)
               begin
                  word_idx <= word_idx + 8'd1;
                  state    <= last_word ? st_idle : st_xfer_req;
               end
            default:
               state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == st_idle && start)
         lba_q <= lba;
   end

   assign busy   = (state != st_idle);
   assign ata_wr = (state == st_wr_req);
   assign ata_rd = (state == st_poll_req) || (state == st_xfer_req);

   always_comb
   begin
      if (state == st_poll_req || state == st_poll_wait)
         ata_addr = ata_pkg::tf_cmd_status;
      else if (state == st_xfer_req || state == st_xfer_wait)
         ata_addr = ata_pkg::tf_data;
      else
         ata_addr = tf_addr;
   end

   assign ata_in = tf_value;

   assign finish = ata_done && ((state == st_poll_wait && status_err) ||
                                (state == st_xfer_wait && last_word));
   assign failed = (state == st_poll_wait);

   // each data word lands in the buffer on its done pulse
   assign wr_en   = ata_done && (state == st_xfer_wait);
   assign wr_addr = word_idx;
   assign wr_data = ata_out;

endmodule

`default_nettype wire

/* rtl/ata_host_regs.sv */
// Host register block for the sector reader.
// Holds the LBA, starts a read on go and keeps sticky done/error flags.
`timescale 1ns/1ps
`default_nettype none

module ata_host_regs (
   input  wire logic        clk,
   input  wire logic        reset,
   input  wire logic        host_wr,
   input  wire logic [2:0]  host_addr,
   input  wire logic [15:0] host_wdata,
   output logic      [15:0] host_rdata,
   output logic             start,
   output logic      [27:0] lba,
   input  wire logic        busy,
   input  wire logic        finish,
   input  wire logic        failed
);

   logic [15:0] lba_lo;
   logic [11:0] lba_hi;
   logic        done_flag;
   logic        err_flag;
   logic        go_accept;

   // a start still in flight counts as busy
   assign go_accept = host_wr && (host_addr == ata_pkg::reg_ctrl) && host_wdata[0] &&
                      !busy && !start;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         lba_lo    <= '0;
         lba_hi    <= '0;
         start     <= 1'b0;
         done_flag <= 1'b0;
         err_flag  <= 1'b0;
      end
      else
      begin
         start <= go_accept;
         if (host_wr && host_addr == ata_pkg::reg_lba_lo)
            lba_lo <= host_wdata;
         if (host_wr && host_addr == ata_pkg::reg_lba_hi)
            lba_hi <= host_wdata[11:0];
         if (go_accept)
         begin
            done_flag <= 1'b0;
            err_flag  <= 1'b0;
         end
         else if (finish)
         begin
            done_flag <= 1'b1;
            err_flag  <= failed;
         end
      end
   end

   assign lba = {lba_hi, lba_lo};

   always_comb
   begin
      case (host_addr)
         ata_pkg::reg_lba_lo: host_rdata = lba_lo;
         ata_pkg::reg_lba_hi: host_rdata = {4'h0, lba_hi};
         ata_pkg::reg_status: host_rdata = {13'h0000, err_flag, done_flag, busy};
         default:             host_rdata = 16'h0000;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/sector_buffer.sv */
// One-sector data buffer.
// Simple dual-port RAM, written by the sequencer, read by the host.
`timescale 1ns/1ps
`default_nettype none

module sector_buffer (
   input  wire logic        clk,
   input  wire logic        wr_en,
   input  wire logic [7:0]  wr_addr,
   input  wire logic [15:0] wr_data,
   input  wire logic [7:0]  rd_addr,
   output logic      [15:0] rd_data
);

   logic [15:0] mem [ata_pkg::sector_words];

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // registered read port
   always_ff @(posedge clk)
   begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

/* rtl/ata_disk_ctrl.sv */
// ATA PIO sector reader, top level.
// Connects the host registers, sequencer, IDE cycle engine and buffer.
`timescale 1ns/1ps
`default_nettype none

module ata_disk_ctrl #(
   parameter logic [5:0] strobe_cycles = 6'd13
) (
   input  wire logic        clk,
   input  wire logic        reset,
   input  wire logic        host_wr,
   input  wire logic [2:0]  host_addr,
   input  wire logic [15:0] host_wdata,
   output logic      [15:0] host_rdata,
   input  wire logic [7:0]  buf_addr,
   output logic      [15:0] buf_data,
   input  wire logic [15:0] ide_data_in,
   output logic      [15:0] ide_data_out,
   output logic             ide_dior,
   output logic             ide_diow,
   output logic      [1:0]  ide_cs,
   output logic      [2:0]  ide_da
);

   logic                           start;
   logic [27:0]                    lba;
   logic                           busy;
   logic                           finish;
   logic                           failed;
   logic                           ata_rd;
   logic                           ata_wr;
   logic [ata_pkg::ata_addr_w-1:0] ata_addr;
   logic [15:0]                    ata_in;
   logic [15:0]                    ata_out;
   logic                           ata_done;
   logic                           wr_en;
   logic [7:0]                     wr_addr;
   logic [15:0]                    wr_data;

   ata_host_regs regs_i (
      .clk        (clk),
      .reset      (reset),
      .host_wr    (host_wr),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_rdata (host_rdata),
      .start      (start),
      .lba        (lba),
      .busy       (busy),
      .finish     (finish),
      .failed     (failed)
   );

   ata_sector_reader reader_i (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .lba      (lba),
      .busy     (busy),
      .finish   (finish),
      .failed   (failed),
      .ata_rd   (ata_rd),
      .ata_wr   (ata_wr),
      .ata_addr (ata_addr),
      .ata_in   (ata_in),
      .ata_out  (ata_out),
      .ata_done (ata_done),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   ata_pio_cycle #(
      .strobe_cycles (strobe_cycles)
   ) pio_i (
      .clk          (clk),
      .reset        (reset),
      .ata_rd       (ata_rd),
      .ata_wr       (ata_wr),
      .ata_addr     (ata_addr),
      .ata_in       (ata_in),
      .ata_out      (ata_out),
      .ata_done     (ata_done),
      .ide_data_in  (ide_data_in),
      .ide_data_out (ide_data_out),
      .ide_dior     (ide_dior),
      .ide_diow     (ide_diow),
      .ide_cs       (ide_cs),
      .ide_da       (ide_da)
   );

   sector_buffer buf_i (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (buf_addr),
      .rd_data (buf_data)
   );

endmodule

`default_nettype wire

/* tests/ide_drive_model.sv */
// Behavioral IDE drive for simulation.
// Captures task-file writes and answers status and data reads
// with a busy phase followed by DRQ or ERR.
`timescale 1ns/1ps
`default_nettype none

module ide_drive_model (
   input  wire logic [15:0] ide_data_out,
   output logic      [15:0] ide_data_in,
   input  wire logic        ide_dior,
   input  wire logic        ide_diow,
   input  wire logic [1:0]  ide_cs,
   input  wire logic [2:0]  ide_da,
   output logic      [7:0]  tf_seccnt,
   output logic      [7:0]  tf_lba0,
   output logic      [7:0]  tf_lba1,
   output logic      [7:0]  tf_lba2,
   output logic      [7:0]  tf_device,
   output logic      [7:0]  tf_command,
   output int               cmd_count
);

   logic [27:0] lba;
   logic [15:0] read_word;
   int          busy_left;
   int          data_idx;

   initial
   begin
      tf_seccnt  = 8'h00;
      tf_lba0    = 8'h00;
      tf_lba1    = 8'h00;
      tf_lba2    = 8'h00;
      tf_device  = 8'h00;
      tf_command = 8'h00;
      cmd_count  = 0;
      busy_left  = 0;
      data_idx   = 0;
      read_word  = 16'h0000;
   end

   assign lba         = {tf_device[3:0], tf_lba2, tf_lba1, tf_lba0};
   assign ide_data_in = ide_dior ? 16'h0000 : read_word;

   // address and write data are already set up when diow falls
   always @(negedge ide_diow)
   begin
      if (ide_cs == 2'b10)
      begin
         case (ide_da)
            3'd2: tf_seccnt = ide_data_out[7:0];
            3'd3: tf_lba0   = ide_data_out[7:0];
            3'd4: tf_lba1   = ide_data_out[7:0];
            3'd5: tf_lba2   = ide_data_out[7:0];
            3'd6: tf_device = ide_data_out[7:0];
            3'd7:
            begin
               tf_command = ide_data_out[7:0];
               if (ide_data_out[7:0] == 8'h20)
               begin
                  busy_left = 3;
                  data_idx  = 0;
                  cmd_count = cmd_count + 1;
               end
            end
            default: ;
         endcase
      end
   end

   // pick the word to drive for the whole strobe
   always @(negedge ide_dior)
   begin
      if (ide_cs == 2'b10 && ide_da == 3'd7)
      begin
         if (busy_left > 0)
         begin
            read_word = 16'h0080;
            busy_left = busy_left - 1;
         end
         else if (lba >= 28'h0100000)
            read_word = 16'h0041;
         else
            read_word = 16'h0048;
      end
      else if (ide_cs == 2'b10 && ide_da == 3'd0)
      begin
         read_word = lba[15:0] ^ (16'(data_idx) * 16'h0101);
         data_idx  = data_idx + 1;
      end
      else
         read_word = 16'h0000;
   end

endmodule

`default_nettype wire

/* tests/ata_pio_checker.sv */
// IDE bus protocol assertions for the PIO cycle engine.
// Strobe exclusion, stable address during a strobe, one-cycle done.
`timescale 1ns/1ps
`default_nettype none

module ata_pio_checker (
   input wire logic       clk,
   input wire logic       reset,
   input wire logic       ide_dior,
   input wire logic       ide_diow,
   input wire logic [1:0] ide_cs,
   input wire logic [2:0] ide_da,
   input wire logic       ata_done
);

   int fail_count;

   initial
      fail_count = 0;

   no_double_strobe: assert property (@(posedge clk) disable iff (reset)
      !(!ide_dior && !ide_diow))
   else
   begin
      $error("dior and diow low at the same time");
      fail_count++;
   end

   // register address must not move under an active strobe
   addr_stable: assert property (@(posedge clk) disable iff (reset)
      (!ide_dior || !ide_diow) |-> ($stable(ide_cs) && $stable(ide_da)))
   else
   begin
      $error("cs or da changed while a strobe was low");
      fail_count++;
   end

   done_single: assert property (@(posedge clk) disable iff (reset)
      ata_done |=> !ata_done)
   else
   begin
      $error("ata_done high for more than one cycle");
      fail_count++;
   end

endmodule

bind ata_pio_cycle ata_pio_checker chk_i (
   .clk      (clk),
   .reset    (reset),
   .ide_dior (ide_dior),
   .ide_diow (ide_diow),
   .ide_cs   (ide_cs),
   .ide_da   (ide_da),
   .ata_done (ata_done)
);

`default_nettype wire

/* tests/ata_disk_ctrl_tb.sv */
// Testbench for the ATA PIO sector reader.
// Drives host register accesses, reads back the sector buffer and
// compares against the drive model's data pattern.
`timescale 1ns/1ps
`default_nettype none

module ata_disk_ctrl_tb;

   localparam int timeout_cycles = 40000;

   logic        clk;
   logic        reset;
   logic        host_wr;
   logic [2:0]  host_addr;
   logic [15:0] host_wdata;
   logic [15:0] host_rdata;
   logic [7:0]  buf_addr;
   logic [15:0] buf_data;
   logic [15:0] ide_data_in;
   logic [15:0] ide_data_out;
   logic        ide_dior;
   logic        ide_diow;
   logic [1:0]  ide_cs;
   logic [2:0]  ide_da;
   logic [7:0]  tf_seccnt;
   logic [7:0]  tf_lba0;
   logic [7:0]  tf_lba1;
   logic [7:0]  tf_lba2;
   logic [7:0]  tf_device;
   logic [7:0]  tf_command;
   int          cmd_count;

   int          errors;
   int          checks;
   int          cycle_count;
   logic        cmp_req;
   logic [27:0] cmp_lba;
   string       cmp_name;
   logic        exp_valid;
   logic [7:0]  exp_idx;

   ata_disk_ctrl #(
      .strobe_cycles (6'd4)
   ) dut_i (
      .clk          (clk),
      .reset        (reset),
      .host_wr      (host_wr),
      .host_addr    (host_addr),
      .host_wdata   (host_wdata),
      .host_rdata   (host_rdata),
      .buf_addr     (buf_addr),
      .buf_data     (buf_data),
      .ide_data_in  (ide_data_in),
      .ide_data_out (ide_data_out),
      .ide_dior     (ide_dior),
      .ide_diow     (ide_diow),
      .ide_cs       (ide_cs),
      .ide_da       (ide_da)
   );

   ide_drive_model drive_i (
      .ide_data_out (ide_data_out),
      .ide_data_in  (ide_data_in),
      .ide_dior     (ide_dior),
      .ide_diow     (ide_diow),
      .ide_cs       (ide_cs),
      .ide_da       (ide_da),
      .tf_seccnt    (tf_seccnt),
      .tf_lba0      (tf_lba0),
      .tf_lba1      (tf_lba1),
      .tf_lba2      (tf_lba2),
      .tf_device    (tf_device),
      .tf_command   (tf_command),
      .cmd_count    (cmd_count)
   );

   always #10 clk = ~clk;

   // data word i of a sector at the given LBA
   function automatic logic [15:0] expected_word(input logic [27:0] lba, input logic [7:0] i);
      return lba[15:0] ^ ({8'h00, i} * 16'h0101);
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("[ERROR] %s: expected %h, got %h", name, exp, act);
      errors++;
   endtask

   task automatic host_write(input logic [2:0] addr, input logic [15:0] data);
      @(posedge clk);
      #1;
      host_wr    = 1'b1;
      host_addr  = addr;
      host_wdata = data;
      @(posedge clk);
      #1;
      host_wr = 1'b0;
   endtask

   task automatic read_status(output logic [15:0] st);
      @(posedge clk);
      #1;
      host_addr = ata_pkg::reg_status;
      @(negedge clk);
      st = host_rdata;
   endtask

   task automatic start_read(input logic [27:0] lba);
      host_write(ata_pkg::reg_lba_lo, lba[15:0]);
      host_write(ata_pkg::reg_lba_hi, {4'h0, lba[27:16]});
      host_write(ata_pkg::reg_ctrl, 16'h0001);
   endtask

   task automatic wait_done(output logic [15:0] st);
      do
         read_status(st);
      while (st[1] !== 1'b1);
   endtask

   // the compare process below checks each word one cycle later
   task automatic check_buffer(input logic [27:0] lba, input string name);
      cmp_lba  = lba;
      cmp_name = name;
      for (int i = 0; i < ata_pkg::sector_words; i++)
      begin
         @(posedge clk);
         #1;
         buf_addr = 8'(i);
         cmp_req  = 1'b1;
      end
      @(posedge clk);
      #1;
      cmp_req = 1'b0;
      @(posedge clk);
   endtask

   task automatic check_taskfile(input logic [27:0] lba, input string name);
      checks++;
      if (tf_seccnt !== 8'h01)
         report_mismatch({name, " seccnt"}, 8'h01, tf_seccnt);
      if (tf_lba0 !== lba[7:0])
         report_mismatch({name, " lba0"}, lba[7:0], tf_lba0);
      if (tf_lba1 !== lba[15:8])
         report_mismatch({name, " lba1"}, lba[15:8], tf_lba1);
      if (tf_lba2 !== lba[23:16])
         report_mismatch({name, " lba2"}, lba[23:16], tf_lba2);
      if (tf_device !== {4'hE, lba[27:24]})
         report_mismatch({name, " device"}, {4'hE, lba[27:24]}, tf_device);
      if (tf_command !== 8'h20)
         report_mismatch({name, " command"}, 8'h20, tf_command);
   endtask

   always @(posedge clk)
   begin
      exp_valid <= cmp_req;
      exp_idx   <= buf_addr;
   end

   always @(negedge clk)
   begin
      if (exp_valid)
      begin
         checks++;
         if (buf_data !== expected_word(cmp_lba, exp_idx))
            report_mismatch(cmp_name, expected_word(cmp_lba, exp_idx), buf_data);
      end
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= timeout_cycles)
      begin
         $display("timeout after %0d cycles, a transfer did not finish", cycle_count);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial
   begin
      logic [15:0] st;
      logic [27:0] lba;
      logic [27:0] lba_a;
      int          cmds_before;

      void'($urandom(32'h8253_67f0));
      clk         = 1'b0;
      reset       = 1'b1;
      host_wr     = 1'b0;
      host_addr   = 3'd0;
      host_wdata  = 16'h0000;
      buf_addr    = 8'h00;
      cmp_req     = 1'b0;
      cmp_lba     = '0;
      cmp_name    = "";
      errors      = 0;
      checks      = 0;
      cycle_count = 0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;

      // idle state after reset
      read_status(st);
      checks++;
      if (st !== 16'h0000)
         report_mismatch("reset status", 16'h0000, st);
      if ({ide_dior, ide_diow, ide_cs, ide_da} !== 7'b11_11_111)
         report_mismatch("reset ide pins", 7'b11_11_111, {ide_dior, ide_diow, ide_cs, ide_da});

      lba = 28'h0012345;
      start_read(lba);
      wait_done(st);
      if (st !== 16'h0002)
         report_mismatch("fixed lba status", 16'h0002, st);
      check_taskfile(lba, "fixed lba taskfile");
      check_buffer(lba, "fixed lba data");

      for (int n = 0; n < 3; n++)
      begin
         lba = 28'($urandom % 32'h0010_0000);
         start_read(lba);
         wait_done(st);
         if (st !== 16'h0002)
            report_mismatch("random lba status", 16'h0002, st);
         check_taskfile(lba, "random lba taskfile");
         check_buffer(lba, "random lba data");
      end

      // drive reports ERR above its last sector
      lba = 28'h0200000;
      start_read(lba);
      wait_done(st);
      if (st !== 16'h0006)
         report_mismatch("error lba status", 16'h0006, st);
      check_taskfile(lba, "error lba taskfile");

      // second go during a transfer must be dropped
      lba_a       = 28'h00a5c3e;
      cmds_before = cmd_count;
      start_read(lba_a);
      do
         read_status(st);
      while (st[0] !== 1'b1);
      host_write(ata_pkg::reg_lba_lo, 16'hffff);
      host_write(ata_pkg::reg_ctrl, 16'h0001);
      wait_done(st);
      if (st !== 16'h0002)
         report_mismatch("busy go status", 16'h0002, st);
      if (cmd_count !== cmds_before + 1)
         report_mismatch("busy go command count", cmds_before + 1, cmd_count);
      check_taskfile(lba_a, "busy go taskfile");
      check_buffer(lba_a, "busy go data");

      errors = errors + dut_i.pio_i.chk_i.fail_count;
      $display("checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, dut_i.pio_i.chk_i.fail_count);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* ata_disk_ctrl.f */
rtl/ata_pkg.sv
rtl/ata_pio_cycle.sv
rtl/ata_sector_reader.sv
rtl/ata_host_regs.sv
rtl/sector_buffer.sv
rtl/ata_disk_ctrl.sv
tests/ide_drive_model.sv
tests/ata_pio_checker.sv
tests/ata_disk_ctrl_tb.sv
